//--- rtl/calc_pkg.sv
// calculator token types

package calc_pkg;

  // ------------------------------
  // operand and result word
  // ------------------------------

  // every stack entry and ALU operand is one of these
  typedef logic [15:0] word_t;

  // ------------------------------
  // operation codes
  // ------------------------------

  // push carries an operand, the rest act on the stack top
  typedef enum logic [3:0] {
    op_push = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_mul  = 4'd3,
    op_and  = 4'd4,
    op_xor  = 4'd5,
    op_neg  = 4'd6,
    op_dup  = 4'd7,
    op_drop = 4'd8
  } opcode_t;

  // ------------------------------
  // input token
  // ------------------------------

  // opcode in the upper 4 bits, operand in the lower 16
  typedef struct packed {
    opcode_t op;
    word_t   operand;
  } token_t;

endpackage

//--- rtl/status_pkg.sv
// calculator status types

package status_pkg;

  // ------------------------------
  // error codes
  // ------------------------------

  // last verdict on an accepted token
  typedef enum logic [1:0] {
    err_none      = 2'd0,
    err_underflow = 2'd1,
    err_overflow  = 2'd2
  } err_t;

  // ------------------------------
  // status word
  // ------------------------------

  // code holds until the next accepted token
  // err is a single cycle strobe per rejected token
  typedef struct packed {
    err_t code;
    logic err;
  } status_t;

endpackage

//--- rtl/lifo.sv
// stack storage with fall-through top
`timescale 1ns/10ps

module lifo import calc_pkg::*; #(
  // number of entries as a power of two
  parameter int DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 nrst,
  // write side
  input  logic                 push,
  input  logic                 pop,
  input  word_t                push_data,
  // read side
  output word_t                top,
  output logic [$clog2(DEPTH):0] cnt
);

  // address width
  // count has one extra bit for the full state
  localparam int AW = $clog2(DEPTH);

  // ------------------------------
  // storage
  // ------------------------------

  // entry 0 is the bottom of the stack
  word_t mem [DEPTH];

  // next free slot and current top slot
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] top_addr;
  logic [AW-1:0] mem_addr;
  logic          empty;

  assign empty    = (cnt == '0);
  assign wr_addr  = cnt[AW-1:0];
  assign top_addr = wr_addr - 1'b1;

  // push alone fills the free slot
  // push with pop overwrites the top in place
  assign mem_addr = pop ? top_addr : wr_addr;

  // single write port, one entry per edge
  always_ff @(posedge clk) begin
    if (push) begin
      mem[mem_addr] <= push_data;
    end
  end

  // ------------------------------
  // entry count
  // ------------------------------

  // the sequencer never pops empty or pushes full
  always_ff @(posedge clk) begin
    if (!nrst) begin
      cnt <= '0;
    end else begin
      case ({push, pop})
        // grow by one
        2'b10: begin
          cnt <= cnt + 1'b1;
        end
        // shrink by one
        2'b01: begin
          cnt <= cnt - 1'b1;
        end
        // count stays on idle or replace
        default: begin
        end
      endcase
    end
  end

  // ------------------------------
  // fall-through output
  // ------------------------------

  // top entry visible without a read strobe
  // zero when nothing is stored
  always_comb begin
    if (empty) begin
      top = '0;
    end else begin
      top = mem[top_addr];
    end
  end

endmodule

//--- rtl/op_alu.sv
// calculator arithmetic unit
`timescale 1ns/10ps

module op_alu import calc_pkg::*; (
  input  opcode_t op,
  // a is the lower entry, b the former top
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  // ------------------------------
  // result select
  // ------------------------------

  // purely combinational, no clock
  always_comb begin
    case (op)
      // binary ops, a op b
      op_add: begin
        result = a + b;
      end
      op_sub: begin
        result = a - b;
      end
      // low half of the product only
      op_mul: begin
        result = a * b;
      end
      op_and: begin
        result = a & b;
      end
      op_xor: begin
        result = a ^ b;
      end
      // two's complement of a
      op_neg: begin
        result = '0 - a;
      end
      // pass a through, dup relies on this
      default: begin
        result = a;
      end
    endcase
  end

endmodule

//--- rtl/rpn_seq.sv
// token sequencer for the stack calculator
`timescale 1ns/10ps

module rpn_seq import calc_pkg::*; import status_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   nrst,
  // token input
  input  logic                   tok_valid,
  input  token_t                 tok,
  // stack feedback
  input  word_t                  top,
  input  logic [$clog2(DEPTH):0] cnt,
  // ALU
  input  word_t                  result,
  output opcode_t                alu_op,
  output word_t                  alu_a,
  output word_t                  alu_b,
  // stack control
  output logic                   push,
  output logic                   pop,
  output word_t                  push_data,
  // status
  output logic                   busy,
  output status_t                status
);

  localparam int CNT_W = $clog2(DEPTH) + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // ------------------------------
  // state and payload
  // ------------------------------

  typedef enum logic {
    st_idle,
    st_exec
  } state_t;

  state_t  state;
  // second half of a binary op
  opcode_t op_q;
  word_t   b_q;
  status_t status_q;

  // decode of the offered token
  logic accept;
  logic is_binary;
  logic start_bin;
  err_t chk_err;

  // no handshake, tokens during exec are lost
  assign accept    = tok_valid && (state == st_idle);
  assign start_bin = accept && is_binary && (chk_err == err_none);
  assign busy      = (state == st_exec);
  assign status    = status_q;

  // ------------------------------
  // operand count checks
  // ------------------------------

  always_comb begin
    is_binary = 1'b0;
    chk_err   = err_none;
    case (tok.op)
      op_add, op_sub, op_mul, op_and, op_xor: begin
        is_binary = 1'b1;
        // needs both a and b
        if (cnt < CNT_W'(2)) begin
          chk_err = err_underflow;
        end
      end
      op_push: begin
        if (cnt == FULL_CNT) begin
          chk_err = err_overflow;
        end
      end
      // empty wins over full for dup
      op_dup: begin
        if (cnt == '0) begin
          chk_err = err_underflow;
        end else if (cnt == FULL_CNT) begin
          chk_err = err_overflow;
        end
      end
      op_neg, op_drop: begin
        if (cnt == '0) begin
          chk_err = err_underflow;
        end
      end
      // unknown codes are accepted as no-ops
      default: begin
      end
    endcase
  end

  // ------------------------------
  // stack and ALU drive
  // ------------------------------

  // lifo acts on the edge that takes the token
  always_comb begin
    push      = 1'b0;
    pop       = 1'b0;
    push_data = result;
    alu_op    = tok.op;
    alu_a     = top;
    alu_b     = b_q;
    if (state == st_exec) begin
      // top now holds a, replace it with a op b
      alu_op = op_q;
      push   = 1'b1;
      pop    = 1'b1;
    end else if (accept && (chk_err == err_none)) begin
      case (tok.op)
        op_push: begin
          push      = 1'b1;
          push_data = tok.operand;
        end
        // ALU passes a through for dup
        op_dup: begin
          push = 1'b1;
        end
        op_drop: begin
          pop = 1'b1;
        end
        // replace top in one cycle
        op_neg: begin
          push = 1'b1;
          pop  = 1'b1;
        end
        // first half of a binary op, b leaves the stack
        op_add, op_sub, op_mul, op_and, op_xor: begin
          pop = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  // ------------------------------
  // registers
  // ------------------------------

  // control state and status
  always_ff @(posedge clk) begin
    if (!nrst) begin
      state    <= st_idle;
      status_q <= '{code: err_none, err: 1'b0};
    end else begin
      status_q.err <= 1'b0;
      if (state == st_exec) begin
        state <= st_idle;
      end else if (accept) begin
        // each accepted token sets or clears the code
        status_q.code <= chk_err;
        status_q.err  <= (chk_err != err_none);
        if (start_bin) begin
          state <= st_exec;
        end
      end
    end
  end

  // latched b and opcode for the exec cycle
  always_ff @(posedge clk) begin
    if (start_bin) begin
      op_q <= tok.op;
      b_q  <= top;
    end
  end

endmodule

//--- rtl/rpn_calc.sv
// stack calculator top level
`timescale 1ns/10ps

module rpn_calc import calc_pkg::*; import status_pkg::*; #(
  // stack entries, power of two
  parameter int DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   tok_valid,
  input  token_t                 tok,
  output word_t                  top,
  output logic [$clog2(DEPTH):0] depth,
  output logic                   busy,
  output status_t                status
);

  // ------------------------------
  // internal nets
  // ------------------------------

  // sequencer to stack
  logic    push;
  logic    pop;
  word_t   push_data;
  // sequencer to ALU and back
  opcode_t alu_op;
  word_t   alu_a;
  word_t   alu_b;
  word_t   result;

  // token decode and operand checks
  rpn_seq #(
    .DEPTH(DEPTH)
  ) i_rpn_seq (
    .clk(clk),
    .nrst(nrst),
    .tok_valid(tok_valid),
    .tok(tok),
    .top(top),
    .cnt(depth),
    .result(result),
    .alu_op(alu_op),
    .alu_a(alu_a),
    .alu_b(alu_b),
    .push(push),
    .pop(pop),
    .push_data(push_data),
    .busy(busy),
    .status(status)
  );

  // arithmetic on the top entries
  op_alu i_op_alu (
    .op(alu_op),
    .a(alu_a),
    .b(alu_b),
    .result(result)
  );

  // operand stack, top and count go straight out
  lifo #(
    .DEPTH(DEPTH)
  ) i_lifo (
    .clk(clk),
    .nrst(nrst),
    .push(push),
    .pop(pop),
    .push_data(push_data),
    .top(top),
    .cnt(depth)
  );

endmodule

//--- tests/tb_rpn_calc.sv
// stack calculator testbench
`timescale 1ns/10ps

module tb_rpn_calc import calc_pkg::*; import status_pkg::*; ();

  localparam int DEPTH = 8;
  localparam int CNT_W = $clog2(DEPTH) + 1;
  localparam int CLK_PERIOD = 40;
  // upper bound on tokens sent by all tests
  // each token takes at most 3 cycles
  localparam int MAX_TOKENS = 100;
  localparam int TIMEOUT_CYCLES = MAX_TOKENS * 3 + 16 + 40;

  logic             clk;
  logic             nrst;
  logic             tok_valid;
  token_t           tok;
  word_t            top;
  logic [CNT_W-1:0] depth;
  logic             busy;
  status_t          status;

  // reference stack with the top as last element
  word_t model_q[$];
  err_t  exp_code;
  int    errors;
  int    checks;
  int    seed;

  rpn_calc #(
    .DEPTH(DEPTH)
  ) i_rpn_calc (
    .clk(clk),
    .nrst(nrst),
    .tok_valid(tok_valid),
    .tok(tok),
    .top(top),
    .depth(depth),
    .busy(busy),
    .status(status)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // reference model
  // ------------------------------

  // rejected tokens leave the queue alone
  task automatic model_step(input opcode_t op, input word_t operand, output err_t e);
    word_t a;
    word_t b;
    word_t r;
    e = err_none;
    case (op)
      op_push: begin
        if (model_q.size() == DEPTH) begin
          e = err_overflow;
        end else begin
          model_q.push_back(operand);
        end
      end
      op_dup: begin
        if (model_q.size() == 0) begin
          e = err_underflow;
        end else if (model_q.size() == DEPTH) begin
          e = err_overflow;
        end else begin
          model_q.push_back(model_q[$]);
        end
      end
      op_drop, op_neg: begin
        if (model_q.size() == 0) begin
          e = err_underflow;
        end else begin
          r = model_q.pop_back();
          // two's complement by invert and add one
          if (op == op_neg) begin
            model_q.push_back(~r + 16'd1);
          end
        end
      end
      default: begin
        if (model_q.size() < 2) begin
          e = err_underflow;
        end else begin
          b = model_q.pop_back();
          a = model_q.pop_back();
          case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_mul:  r = a * b;
            op_and:  r = a & b;
            default: r = a ^ b;
          endcase
          model_q.push_back(r);
        end
      end
    endcase
  endtask

  // ------------------------------
  // checks and token driver
  // ------------------------------

  task automatic check_state(input logic exp_err);
    word_t exp_top;
    exp_top = (model_q.size() == 0) ? 16'h0000 : model_q[$];
    checks += 5;
    assert (top === exp_top) else begin
      errors++;
      $display("ERR %0t top expected %h got %h", $time, exp_top, top);
    end
    assert (depth === CNT_W'(model_q.size())) else begin
      errors++;
      $display("ERR %0t depth expected %0d got %0d", $time, model_q.size(), depth);
    end
    assert (busy === 1'b0) else begin
      errors++;
      $display("ERR %0t busy expected 0 got %b", $time, busy);
    end
    assert (status.code === exp_code) else begin
      errors++;
      $display("ERR %0t status.code expected %s got %s", $time, exp_code.name(),
               status.code.name());
    end
    assert (status.err === exp_err) else begin
      errors++;
      $display("ERR %0t status.err expected %b got %b", $time, exp_err, status.err);
    end
  endtask

  // called and returns a little after a rising edge
  // inject offers a push while busy that must be lost
  task automatic send_token(input opcode_t op, input word_t operand, input logic inject);
    err_t e;
    int   n;
    int   exp_n;
    tok_valid = 1'b1;
    tok       = '{op: op, operand: operand};
    @(posedge clk);
    #2;
    tok_valid = 1'b0;
    model_step(op, operand, e);
    // every accepted token sets or clears the code
    exp_code = e;
    exp_n = (e == err_none && op inside {op_add, op_sub, op_mul, op_and, op_xor}) ? 1 : 0;
    checks += 2;
    assert (status.err === (e != err_none)) else begin
      errors++;
      $display("ERR %0t status.err expected %b got %b", $time, e != err_none, status.err);
    end
    n = 0;
    while (busy === 1'b1 && n < 4) begin
      if (inject) begin
        tok_valid = 1'b1;
        tok       = '{op: op_push, operand: 16'hbeef};
      end
      @(posedge clk);
      #2;
      tok_valid = 1'b0;
      n++;
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("busy did not fall within 4 cycles after %s at %0t", op.name(), $time);
    end
    assert (n == exp_n) else begin
      errors++;
      $display("ERR %0t busy cycles expected %0d got %0d", $time, exp_n, n);
    end
    // top and depth settle on the edge that ends the token
    check_state((n == 0) && (e != err_none));
    // err pulse must be gone after one idle cycle
    @(posedge clk);
    #2;
    check_state(1'b0);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic reset_and_fill();
    int i;
    check_state(1'b0);
    for (i = 0; i < DEPTH; i++) begin
      send_token(op_push, word_t'($random(seed)), 1'b0);
    end
  endtask

  // stack is full on entry
  task automatic lifo_order();
    int i;
    for (i = 0; i < DEPTH; i++) begin
      send_token(op_drop, 16'h0, 1'b0);
    end
    for (i = 0; i < 3; i++) begin
      send_token(op_push, word_t'($random(seed)), 1'b0);
    end
    for (i = 0; i < 3; i++) begin
      send_token(op_drop, 16'h0, 1'b0);
    end
  endtask

  task automatic arith_ops();
    opcode_t ops [5];
    int      i;
    ops = '{op_add, op_sub, op_mul, op_and, op_xor};
    for (i = 0; i < 5; i++) begin
      send_token(op_push, word_t'($random(seed)), 1'b0);
      send_token(op_push, word_t'($random(seed)), 1'b0);
      send_token(ops[i], 16'h0, 1'b0);
      send_token(op_drop, 16'h0, 1'b0);
    end
    // (3+4)*(5-2)
    send_token(op_push, 16'd3, 1'b0);
    send_token(op_push, 16'd4, 1'b0);
    send_token(op_add, 16'h0, 1'b0);
    send_token(op_push, 16'd5, 1'b0);
    send_token(op_push, 16'd2, 1'b0);
    send_token(op_sub, 16'h0, 1'b0);
    send_token(op_mul, 16'h0, 1'b0);
    checks++;
    assert (top === 16'd21) else begin
      errors++;
      $display("ERR %0t top expected %0d got %0d", $time, 16'd21, top);
    end
    send_token(op_drop, 16'h0, 1'b0);
  endtask

  task automatic unary_ops();
    send_token(op_push, word_t'($random(seed)), 1'b0);
    send_token(op_dup, 16'h0, 1'b0);
    send_token(op_neg, 16'h0, 1'b0);
    send_token(op_push, word_t'($random(seed)), 1'b0);
    send_token(op_add, 16'h0, 1'b1);
    send_token(op_drop, 16'h0, 1'b0);
    send_token(op_drop, 16'h0, 1'b0);
  endtask

  // starts and ends with an empty stack
  task automatic error_cases();
    int i;
    send_token(op_drop, 16'h0, 1'b0);
    send_token(op_neg, 16'h0, 1'b0);
    send_token(op_dup, 16'h0, 1'b0);
    send_token(op_push, word_t'($random(seed)), 1'b0);
    send_token(op_add, 16'h0, 1'b0);
    send_token(op_drop, 16'h0, 1'b0);
    for (i = 0; i < DEPTH; i++) begin
      send_token(op_push, word_t'($random(seed)), 1'b0);
    end
    send_token(op_push, 16'h1234, 1'b0);
    send_token(op_dup, 16'h0, 1'b0);
    for (i = 0; i < DEPTH; i++) begin
      send_token(op_drop, 16'h0, 1'b0);
    end
  endtask

  // ------------------------------
  // run control
  // ------------------------------

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    nrst      = 1'b0;
    tok_valid = 1'b0;
    tok       = '0;
    errors    = 0;
    checks    = 0;
    seed      = 32'h0664b06f;
    exp_code  = err_none;
    repeat (16) @(posedge clk);
    #2;
    nrst = 1'b1;
    reset_and_fill();
    lifo_order();
    arith_ops();
    unary_ops();
    error_cases();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
rtl/calc_pkg.sv
rtl/status_pkg.sv
rtl/lifo.sv
rtl/op_alu.sv
rtl/rpn_seq.sv
rtl/rpn_calc.sv
tests/tb_rpn_calc.sv

//--- run.sh
#!/bin/sh
# build and run the calculator testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_rpn_calc \
  -o sim_rpn_calc > build.log 2>&1 &&
  ./obj_dir/sim_rpn_calc > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
exit 0
